/* all.f */
+incdir+src
src/mmr_pkg.sv
src/ctrl_pkg.sv
src/mmr_decode.sv
src/mtimer.sv
src/pipe_ctrl.sv
src/core_ctrl.sv
test/core_ctrl_sva.sv
test/tb_core_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core_ctrl testbench with Verilator and runs it.
# The run passes only when the testbench prints its pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_core_ctrl \
   -f all.f -Mdir obj_dir &&
./obj_dir/Vtb_core_ctrl +verilator+error+limit+1000 | tee /dev/stderr \
   | grep -x "sim passed" > /dev/null &&
echo "run.sh: PASS" ||
{ echo "run.sh: FAIL"; exit 1; }

/* test/tb_core_ctrl.sv */
//------------------------------------------------
// Testbench for core_ctrl with bound assertions doing most checks
// Reads are also compared against expected register values
// Random values stay small so mtime never carries into the high half
//------------------------------------------------
`include "core_config.svh"

module tb_core_ctrl
   import mmr_pkg::*;
   import ctrl_pkg::*;
();

   localparam int TIMEOUT = 200;                   // Cycles per wait loop

   logic              clk_in = 1'b0;
   logic              rst_n;
   mmr_req_t          mmr_req;
   mmr_rsp_t          mmr_rsp;
   redirect_t         exe_redirect;
   wb_redirect_t      wb_redirect;
   logic              wfi;
   logic              ext_irq;
   timer_t            mtime;
   logic              timer_irq;
   logic              sw_irq;
   logic              pc_reload;
   logic              ic_reload;
   logic [`PC_SZ-1:0] pc_reload_addr;
   flush_t            flush;
   logic              cpu_halt;
   int                err_count = 0;
   logic [`XLEN-1:0]  wdata;                       // Last random write data
   timer_t            target;                      // Programmed compare value

   always #4 clk_in = ~clk_in;                     // Period 8

   core_ctrl uut (.*);

   // Inputs change just after the rising edge
   task automatic next_cycle();
      @(posedge clk_in);
      #1;
   endtask

   task automatic reg_write(input logic [`PC_SZ-1:0] addr, input logic [`XLEN-1:0] data);
      mmr_req = '{valid: 1'b1, rd: 1'b0, wr: 1'b1, addr: addr, wr_data: data};
      next_cycle();
      mmr_req = '0;
   endtask

   task automatic reg_read(input string name, input logic [`PC_SZ-1:0] addr,
                           input logic [`XLEN-1:0] exp_data);
      int n;
      mmr_req = '{valid: 1'b1, rd: 1'b1, wr: 1'b0, addr: addr, wr_data: '0};
      next_cycle();
      mmr_req = '0;
      n = 0;
      while (!mmr_rsp.valid && n < TIMEOUT)        // Response due now
      begin
         next_cycle();
         n++;
      end
      if (!mmr_rsp.valid)
      begin
         $display("Timeout: no read response for %s", name);
         err_count++;
      end
      else if (mmr_rsp.rd_data !== exp_data)
      begin
         $display("ERROR %s: expected %h, actual %h", name, exp_data, mmr_rsp.rd_data);
         err_count++;
      end
   endtask

   // Random flags and targets for one cycle
   task automatic redirect_pulse();
      exe_redirect = '{flag: 1'($urandom), addr: $urandom};
      wb_redirect  = '{pc: '{flag: 1'($urandom), addr: $urandom}, ic_flag: 1'($urandom)};
      next_cycle();
      exe_redirect = '0;
      wb_redirect  = '0;
   endtask

   task automatic sleep_wake_pulse(input logic wfi_val, input logic irq_val);
      wfi     = wfi_val;
      ext_irq = irq_val;
      next_cycle();
      wfi     = 1'b0;
      ext_irq = 1'b0;
   endtask

   task automatic wait_halt(input logic level);
      int n;
      n = 0;
      while (cpu_halt !== level && n < TIMEOUT)
      begin
         next_cycle();
         n++;
      end
      if (cpu_halt !== level)
      begin
         $display("Timeout: cpu_halt never went to %b", level);
         err_count++;
      end
   endtask

   task automatic wait_timer_irq();
      int n;
      n = 0;
      while (!timer_irq && n < TIMEOUT)
      begin
         next_cycle();
         n++;
      end
      if (!timer_irq)
      begin
         $display("Timeout: timer_irq never rose");
         err_count++;
      end
   endtask

   initial
   begin
      wdata        = $urandom(14075);              // Seed for the whole run
      rst_n        = 1'b0;
      mmr_req      = '0;
      exe_redirect = '0;
      wb_redirect  = '0;
      wfi          = 1'b0;
      ext_irq      = 1'b0;
      repeat (8) @(posedge clk_in);
      #1 rst_n = 1'b1;

      //------------------------------------------------
      // mtime writes, reads and an unmapped access
      //------------------------------------------------
      wdata = $urandom & 32'h0FFF_FFFF;
      reg_write(`MMR_MTIME_LO_ADDR, wdata);
      reg_read("mtime_lo k=1", `MMR_MTIME_LO_ADDR, wdata);
      wdata = $urandom & 32'h0FFF_FFFF;
      reg_write(`MMR_MTIME_LO_ADDR, wdata);
      repeat (4) next_cycle();                     // Read goes out in cycle 5
      reg_read("mtime_lo k=5", `MMR_MTIME_LO_ADDR, wdata + 32'd4);
      wdata = $urandom & 32'h0000_FFFF;
      reg_write(`MMR_MTIME_HI_ADDR, wdata);
      reg_read("mtime_hi", `MMR_MTIME_HI_ADDR, wdata);
      reg_read("unmapped", `MMR_MSIP_ADDR + 32'h10, '0);
      reg_write(`MMR_MSIP_ADDR + 32'h10, $urandom);  // Must leave every register alone

      // Compare value a little ahead of mtime
      // Writing the high half first avoids an early hit
      target = mtime + 64'd40 + 64'($urandom & 32'h1F);
      reg_write(`MMR_MTIMECMP_HI_ADDR, target[2*`XLEN-1:`XLEN]);
      reg_write(`MMR_MTIMECMP_LO_ADDR, target[`XLEN-1:0]);
      reg_read("mtimecmp_lo", `MMR_MTIMECMP_LO_ADDR, target[`XLEN-1:0]);
      reg_read("mtimecmp_hi", `MMR_MTIMECMP_HI_ADDR, target[2*`XLEN-1:`XLEN]);
      wait_timer_irq();
      if (timer_irq && mtime !== target + 64'd1)   // Irq one cycle after the hit
      begin
         $display("ERROR timer_irq rise: expected %h, actual %h", target + 64'd1, mtime);
         err_count++;
      end
      reg_write(`MMR_MTIMECMP_HI_ADDR, '1);        // Quiet the timer again

      //------------------------------------------------
      // Software interrupt
      //------------------------------------------------
      wdata = $urandom;
      reg_write(`MMR_MSIP_ADDR, wdata);
      reg_read("msip", `MMR_MSIP_ADDR, {{(`XLEN-1){1'b0}}, wdata[0]});
      reg_write(`MMR_MSIP_ADDR, ~wdata);
      reg_read("msip flipped", `MMR_MSIP_ADDR, {{(`XLEN-1){1'b0}}, ~wdata[0]});

      repeat (32) redirect_pulse();

      //------------------------------------------------
      // Halt and wake
      //------------------------------------------------
      sleep_wake_pulse(1'b1, 1'b0);
      wait_halt(1'b1);
      sleep_wake_pulse(1'b0, 1'b1);
      wait_halt(1'b0);
      sleep_wake_pulse(1'b1, 1'b1);                // Both while awake
      if (cpu_halt !== 1'b0)
      begin
         $display("ERROR wfi with ext_irq: expected 0, actual %b", cpu_halt);
         err_count++;
      end
      sleep_wake_pulse(1'b1, 1'b0);
      wait_halt(1'b1);
      sleep_wake_pulse(1'b1, 1'b1);                // Both while halted
      wait_halt(1'b0);

      next_cycle();                                // Last assertion sample
      $display("Errors: %0d, assertion failures: %0d", err_count, uut.u_sva.fail_count);
      if (err_count == 0 && uut.u_sva.fail_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* test/core_ctrl_sva.sv */
//------------------------------------------------
// Concurrent checks for core_ctrl, attached by bind
// Uses the internal mtimecmp of the bound scope
// Sequential checks skip the first edge after reset
//------------------------------------------------
`include "core_config.svh"

module core_ctrl_sva
   import mmr_pkg::*;
   import ctrl_pkg::*;
(
   input logic                clk_in,
   input logic                rst_n,
   input mmr_req_t            mmr_req,
   input mmr_rsp_t            mmr_rsp,
   input redirect_t           exe_redirect,
   input wb_redirect_t        wb_redirect,
   input logic                wfi,
   input logic                ext_irq,
   input timer_t              mtime,
   input timer_t              mtimecmp,         // Internal to core_ctrl
   input logic                timer_irq,
   input logic                sw_irq,
   input logic                pc_reload,
   input logic                ic_reload,
   input logic [`PC_SZ-1:0]   pc_reload_addr,
   input flush_t              flush,
   input logic                cpu_halt
);

   int   fail_count = 0;                           // Read by the testbench at the end
   logic wr_en;                                    // Store this cycle
   logic rd_en;                                    // Load this cycle
   logic mapped;                                   // Address hits a timer register
   logic any_flag;

   assign wr_en    = mmr_req.valid & mmr_req.wr;
   assign rd_en    = mmr_req.valid & mmr_req.rd;
   assign any_flag = exe_redirect.flag | wb_redirect.pc.flag;
   assign mapped   = mmr_req.addr inside {`MMR_MSIP_ADDR, `MMR_MTIMECMP_LO_ADDR,
                     `MMR_MTIMECMP_HI_ADDR, `MMR_MTIME_LO_ADDR, `MMR_MTIME_HI_ADDR};

   task automatic record_failure(input string what);
      fail_count++;
      $error("%s", what);
   endtask

   //------------------------------------------------
   // Reset and timer registers
   //------------------------------------------------
   a_reset: assert property (@(posedge clk_in) $rose(rst_n) |-> !timer_irq && !sw_irq
      && !cpu_halt && !mmr_rsp.valid && !pc_reload && mtime == '0)
      else record_failure("outputs not at reset values after reset");
   a_count: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      && !$past(wr_en && mmr_req.addr inside {`MMR_MTIME_LO_ADDR, `MMR_MTIME_HI_ADDR})
      |-> mtime == $past(mtime) + 64'd1) else record_failure("mtime did not count by one");
   a_mtime_lo: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      && $past(wr_en && mmr_req.addr == `MMR_MTIME_LO_ADDR) |-> mtime[`XLEN-1:0] ==
      $past(mmr_req.wr_data) && mtime[2*`XLEN-1:`XLEN] == $past(mtime[2*`XLEN-1:`XLEN]))
      else record_failure("mtime low half write lost");
   a_mtime_hi: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      && $past(wr_en && mmr_req.addr == `MMR_MTIME_HI_ADDR) |-> mtime[2*`XLEN-1:`XLEN] ==
      $past(mmr_req.wr_data) && mtime[`XLEN-1:0] == $past(mtime[`XLEN-1:0]))
      else record_failure("mtime high half write lost");
   a_timer_irq: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      |-> timer_irq == ($past(mtime) >= $past(mtimecmp)))
      else record_failure("timer_irq does not follow the compare by one cycle");
   a_sw_irq: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      |-> sw_irq == ($past(wr_en && mmr_req.addr == `MMR_MSIP_ADDR) ?
      $past(mmr_req.wr_data[0]) : $past(sw_irq))) else record_failure("sw_irq wrong");

   //------------------------------------------------
   // Read response
   //------------------------------------------------
   a_rsp_valid: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      |-> mmr_rsp.valid == $past(rd_en)) else record_failure("read response timing wrong");
   a_rsp_fault: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      && $past(rd_en) |-> mmr_rsp.fault == !$past(mapped)
      && ($past(mapped) || mmr_rsp.rd_data == '0))
      else record_failure("read fault flag wrong or unmapped read with data");

   // Redirect outputs are combinational and checked in the same cycle
   a_redirect: assert property (@(posedge clk_in) disable iff (!rst_n) pc_reload == any_flag
      && pc_reload_addr == (wb_redirect.pc.flag ? wb_redirect.pc.addr : exe_redirect.addr))
      else record_failure("fetch redirect wrong");
   a_flush: assert property (@(posedge clk_in) disable iff (!rst_n) flush.dec == any_flag
      && flush.exe == any_flag && flush.mem == wb_redirect.pc.flag
      && ic_reload == wb_redirect.ic_flag) else record_failure("stage flush wrong");
   a_halt: assert property (@(posedge clk_in) disable iff (!rst_n) $past(rst_n)
      |-> cpu_halt == ($past(ext_irq) ? 1'b0 : ($past(wfi) ? 1'b1 : $past(cpu_halt))))
      else record_failure("cpu_halt did not follow wfi and ext_irq");

endmodule

// Attach to every core_ctrl instance
bind core_ctrl core_ctrl_sva u_sva (.*);

/* src/core_ctrl.sv */
//------------------------------------------------
// Core level control between the pipeline stages
// Stage requests arrive as plain strobes and levels
//------------------------------------------------
`include "core_config.svh"

module core_ctrl
   import mmr_pkg::*;
   import ctrl_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst_n,

   // MEM stage register access
   input  mmr_req_t           mmr_req,
   output mmr_rsp_t           mmr_rsp,

   // Stage redirect requests
   input  redirect_t          exe_redirect,
   input  wb_redirect_t       wb_redirect,
   input  logic               wfi,
   input  logic               ext_irq,

   // Timer and interrupts
   output timer_t             mtime,               // To the CSR file
   output logic               timer_irq,
   output logic               sw_irq,

   // Fetch and pipeline control
   output logic               pc_reload,
   output logic               ic_reload,
   output logic [`PC_SZ-1:0]  pc_reload_addr,
   output flush_t             flush,
   output logic               cpu_halt
);

   mmr_wr_t mmr_wr;                                // Decoded store strobes
   timer_t  mtimecmp;                              // Read back through the decoder
   logic    msip;

   //------------------------------------------------
   // Memory-mapped timer registers
   //------------------------------------------------
   mmr_decode u_decode
   (
      .clk_in     (clk_in),
      .rst_n      (rst_n),
      .mmr_req    (mmr_req),
      .mtime      (mtime),
      .mtimecmp   (mtimecmp),
      .msip       (msip),
      .mmr_wr     (mmr_wr),
      .mmr_rsp    (mmr_rsp)
   );

   mtimer u_timer
   (
      .clk_in     (clk_in),
      .rst_n      (rst_n),
      .mmr_wr     (mmr_wr),
      .mtime      (mtime),
      .mtimecmp   (mtimecmp),
      .msip       (msip),
      .timer_irq  (timer_irq),
      .sw_irq     (sw_irq)
   );

   //------------------------------------------------
   // Redirects, flushes and halt
   //------------------------------------------------
   pipe_ctrl u_pipe
   (
      .clk_in         (clk_in),
      .rst_n          (rst_n),
      .exe_redirect   (exe_redirect),
      .wb_redirect    (wb_redirect),
      .wfi            (wfi),
      .ext_irq        (ext_irq),
      .pc_reload      (pc_reload),
      .ic_reload      (ic_reload),
      .pc_reload_addr (pc_reload_addr),
      .flush          (flush),
      .cpu_halt       (cpu_halt)
   );

endmodule

/* src/pipe_ctrl.sv */
//------------------------------------------------
// Fetch redirect select, stage flushes and halt/wake
// Redirect and flush outputs are combinational from the stage flags
// ext_irq wakes the core even when wfi arrives in the same cycle
//------------------------------------------------
`include "core_config.svh"

module pipe_ctrl
   import ctrl_pkg::*;
(
   input  logic               clk_in,
   input  logic               rst_n,
   input  redirect_t          exe_redirect,        // Branch mispredict
   input  wb_redirect_t       wb_redirect,         // Trap or I-cache reload
   input  logic               wfi,                 // Single cycle pulse from write-back
   input  logic               ext_irq,             // Level
   output logic               pc_reload,
   output logic               ic_reload,
   output logic [`PC_SZ-1:0]  pc_reload_addr,
   output flush_t             flush,
   output logic               cpu_halt
);

   logic exe_flag;
   logic wb_flag;
   logic any_flag;                                 // Either stage wants a redirect

   assign exe_flag = exe_redirect.flag;
   assign wb_flag  = wb_redirect.pc.flag;
   assign any_flag = exe_flag | wb_flag;

   //------------------------------------------------
   // Redirect priority
   //------------------------------------------------
   // Write-back holds the older instruction, so it wins
   assign pc_reload      = any_flag;
   assign pc_reload_addr = wb_flag ? wb_redirect.pc.addr : exe_redirect.addr;
   assign ic_reload      = wb_redirect.ic_flag;    // Refetch after self-modifying store

   //------------------------------------------------
   // Stage flushes
   //------------------------------------------------
   // A mispredict only kills the stages younger than execute
   // The instruction already in MEM is kept
   always_comb
   begin
      flush.dec = any_flag;
      flush.exe = any_flag;
      flush.mem = wb_flag;                         // Trap also kills MEM
   end

   //------------------------------------------------
   // Halt and wake
   //------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         cpu_halt <= 1'b0;
      else if (ext_irq)
         cpu_halt <= 1'b0;                         // Wake has priority
      else if (wfi)
         cpu_halt <= 1'b1;                         // Sleep until an interrupt
   end

endmodule

/* src/mtimer.sv */
//------------------------------------------------
// Machine timer with mtime, mtimecmp and msip
// mtime counts core clocks without a prescaler
// Halves are written one at a time, so a 64-bit update is not atomic
//------------------------------------------------
`include "core_config.svh"

module mtimer
   import mmr_pkg::*;
(
   input  logic      clk_in,
   input  logic      rst_n,
   input  mmr_wr_t   mmr_wr,                       // Decoded store strobes
   output timer_t    mtime,                        // Also read by the CSR file
   output timer_t    mtimecmp,
   output logic      msip,
   output logic      timer_irq,                    // Registered compare result
   output logic      sw_irq
);

   logic timer_hit;                                // mtime has reached mtimecmp

   //------------------------------------------------
   // mtime counter
   //------------------------------------------------
   // A written half loads the data
   // The other half holds for that cycle
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         mtime <= '0;
      else if (mmr_wr.mtime_lo)
         mtime <= {mtime[2*`XLEN-1:`XLEN], mmr_wr.data};
      else if (mmr_wr.mtime_hi)
         mtime <= {mmr_wr.data, mtime[`XLEN-1:0]};
      else
         mtime <= mtime + 1'b1;                    // Free running
   end

   //------------------------------------------------
   // Compare register
   //------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         mtimecmp <= `MTIMECMP_RESET;
      else if (mmr_wr.mtimecmp_lo)
         mtimecmp <= {mtimecmp[2*`XLEN-1:`XLEN], mmr_wr.data};
      else if (mmr_wr.mtimecmp_hi)
         mtimecmp <= {mmr_wr.data, mtimecmp[`XLEN-1:0]};
   end

   // Software interrupt pending bit
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         msip <= 1'b0;
      else if (mmr_wr.msip)
         msip <= mmr_wr.data[0];                   // Upper bits ignored
   end

   //------------------------------------------------
   // Interrupt generation
   //------------------------------------------------
   // Unsigned 64-bit compare
   assign timer_hit = (mtime >= mtimecmp);

   // One cycle behind the compare
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         timer_irq <= 1'b0;
      else
         timer_irq <= timer_hit;
   end

   assign sw_irq = msip;                           // Level held until a store clears msip

endmodule

/* src/mmr_decode.sv */
//------------------------------------------------
// Decodes MEM stage accesses to the timer registers
// Writes are strobed in the same cycle, reads answer one cycle later
// Every request is accepted without back-pressure
//------------------------------------------------
`include "core_config.svh"

module mmr_decode
   import mmr_pkg::*;
(
   input  logic      clk_in,
   input  logic      rst_n,
   input  mmr_req_t  mmr_req,                      // From MEM stage
   input  timer_t    mtime,                        // Current register values for reads
   input  timer_t    mtimecmp,
   input  logic      msip,
   output mmr_wr_t   mmr_wr,                       // To mtimer
   output mmr_rsp_t  mmr_rsp                       // Back to MEM stage
);

   logic             wr_en;                        // Valid store
   logic             rd_en;                        // Valid load
   logic [`XLEN-1:0] rd_data;                      // Selected read word
   logic             rd_fault;                     // No register at this address
   logic             rsp_valid;
   logic             rsp_fault;
   logic [`XLEN-1:0] rsp_data;

   assign wr_en = mmr_req.valid & mmr_req.wr;
   assign rd_en = mmr_req.valid & mmr_req.rd;

   //------------------------------------------------
   // Address decode
   //------------------------------------------------
   always_comb
   begin
      mmr_wr      = '0;
      mmr_wr.data = mmr_req.wr_data;               // Data passes straight through
      rd_data     = '0;                            // Unmapped reads return zero
      rd_fault    = 1'b1;
      case (mmr_req.addr)
         `MMR_MSIP_ADDR:
         begin
            mmr_wr.msip = wr_en;
            rd_data     = {{(`XLEN-1){1'b0}}, msip};   // Zero extended
            rd_fault    = 1'b0;
         end
         `MMR_MTIMECMP_LO_ADDR:
         begin
            mmr_wr.mtimecmp_lo = wr_en;
            rd_data            = mtimecmp[`XLEN-1:0];
            rd_fault           = 1'b0;
         end
         `MMR_MTIMECMP_HI_ADDR:
         begin
            mmr_wr.mtimecmp_hi = wr_en;
            rd_data            = mtimecmp[2*`XLEN-1:`XLEN];
            rd_fault           = 1'b0;
         end
         `MMR_MTIME_LO_ADDR:
         begin
            mmr_wr.mtime_lo = wr_en;
            rd_data         = mtime[`XLEN-1:0];
            rd_fault        = 1'b0;
         end
         `MMR_MTIME_HI_ADDR:
         begin
            mmr_wr.mtime_hi = wr_en;
            rd_data         = mtime[2*`XLEN-1:`XLEN];
            rd_fault        = 1'b0;
         end
         default: ;                                // Writes here are dropped
      endcase
   end

   //------------------------------------------------
   // Read response register
   //------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rsp_valid <= 1'b0;
         rsp_fault <= 1'b0;
      end
      else
      begin
         rsp_valid <= rd_en;
         rsp_fault <= rd_en & rd_fault;
      end
   end

   // Value sampled before the edge, so a same-cycle write is not seen
   always_ff @(posedge clk_in)
   begin
      if (rd_en)
         rsp_data <= rd_data;
   end

   assign mmr_rsp = '{valid: rsp_valid, fault: rsp_fault, rd_data: rsp_data};

endmodule

/* src/ctrl_pkg.sv */
//------------------------------------------------
// Types for fetch redirects and stage flushes
// Redirect flags are single cycle strobes from the stages
//------------------------------------------------
`include "core_config.svh"

package ctrl_pkg;

   //------------------------------------------------
   // Redirect request, 33 bits
   //------------------------------------------------
   typedef struct packed
   {
      logic                flag;                   // Reload the fetch PC
      logic [`PC_SZ-1:0]   addr;                   // New fetch PC
   } redirect_t;

   // Write-back redirect also covers I-cache reload, 34 bits
   typedef struct packed
   {
      redirect_t           pc;                     // Trap or reload target
      logic                ic_flag;                // Store hit the instruction space
   } wb_redirect_t;

   // Per-stage flush, 3 bits
   typedef struct packed
   {
      logic                dec;
      logic                exe;
      logic                mem;                    // Only write-back redirects reach MEM
   } flush_t;

endpackage

/* src/mmr_pkg.sv */
//------------------------------------------------
// Types for memory-mapped timer register accesses
// A request carries exactly one of rd or wr when valid
//------------------------------------------------
`include "core_config.svh"

package mmr_pkg;

   // 64-bit timer value, used for mtime and mtimecmp
   typedef logic [2*`XLEN-1:0] timer_t;

   //------------------------------------------------
   // MEM stage access, 67 bits
   //------------------------------------------------
   typedef struct packed
   {
      logic                valid;                  // Single cycle strobe
      logic                rd;                     // Load
      logic                wr;                     // Store
      logic [`PC_SZ-1:0]   addr;                   // Byte address of the word
      logic [`XLEN-1:0]    wr_data;                // Store data
   } mmr_req_t;

   // Read response, 34 bits
   typedef struct packed
   {
      logic                valid;                  // One cycle after the read request
      logic                fault;                  // Address matched no register
      logic [`XLEN-1:0]    rd_data;                // Zero on fault
   } mmr_rsp_t;

   // Decoded write strobes, 37 bits
   typedef struct packed
   {
      logic                msip;
      logic                mtime_lo;
      logic                mtime_hi;
      logic                mtimecmp_lo;
      logic                mtimecmp_hi;
      logic [`XLEN-1:0]    data;                   // Shared by all strobes
   } mmr_wr_t;

endpackage

/* src/core_config.svh */
//------------------------------------------------
// Shared widths and machine timer register map
// Register addresses are full byte addresses of 32-bit words
// Only aligned word accesses are decoded
//------------------------------------------------
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

//------------------------------------------------
// Datapath widths
//------------------------------------------------
`define XLEN                  32                   // Register data width
`define PC_SZ                 32                   // Address width

//------------------------------------------------
// Machine timer register map
//------------------------------------------------
// Layout follows the usual CLINT offsets
`define MMR_MSIP_ADDR         32'h0200_0000        // Software interrupt pending
`define MMR_MTIMECMP_LO_ADDR  32'h0200_4000        // Compare value bits 31:0
`define MMR_MTIMECMP_HI_ADDR  32'h0200_4004        // Compare value bits 63:32
`define MMR_MTIME_LO_ADDR     32'h0200_BFF8        // Free running time bits 31:0
`define MMR_MTIME_HI_ADDR     32'h0200_BFFC        // Free running time bits 63:32

// All ones keeps timer_irq quiet until software programs a compare value
`define MTIMECMP_RESET        64'hFFFF_FFFF_FFFF_FFFF

`endif
